//--- source/miner_link_pkg.sv
// all widths are fixed by the frame format; frames and records are big-endian, msb byte first
`default_nettype none

package miner_link_pkg;

	// ************************************************************************
	// field widths
	// ************************************************************************
	localparam int BYTE_W   = 8;                              // link byte
	localparam int WORD_W   = 32;                             // nonce and extranonce2
	localparam int BLOCK_W  = 608;                            // block data
	localparam int TARGET_W = 256;                            // mining target
	localparam int JOB_W    = BLOCK_W + WORD_W + TARGET_W;    // 896 bits per job

	// frame is control byte plus the job, 113 bytes
	localparam int FRAME_BYTES = 1 + JOB_W / BYTE_W;

	// result record is flag byte, nonce, extranonce2
	localparam int RECORD_W     = BYTE_W + 2 * WORD_W;
	localparam int RECORD_BYTES = RECORD_W / BYTE_W;          // 9 bytes on the wire

	// ************************************************************************
	// queue sizing and restart handling
	// ************************************************************************
	localparam int JOB_DEPTH    = 16;   // pending merkle jobs
	localparam int RESULT_DEPTH = 16;   // pending nonce records
	localparam int BLANK_CYCLES = 5;    // reports dropped this long after a restart

	// control byte of a command frame
	typedef enum logic [BYTE_W-1:0] {
		OP_NONE    = 8'h00,    // reset value, also any unknown code
		OP_RESTART = 8'h01,    // load now and flush pending work
		OP_MERKLE  = 8'h02     // queue for later
	} ctrl_op_e;

	// job as it sits in the frame, block first
	typedef struct packed {
		logic [BLOCK_W-1:0]  block;
		logic [WORD_W-1:0]   extranonce2;
		logic [TARGET_W-1:0] target;
	} job_t;

endpackage

`default_nettype wire

//--- source/job_if.sv
// strobes are single-cycle and the job is only meaningful while restart or push is high
`timescale 1ns/1ps
`default_nettype none

interface job_if;

	import miner_link_pkg::*;

	logic restart;    // one-cycle pulse, restart frame complete
	logic push;       // one-cycle pulse, merkle frame complete
	job_t job;        // decoded job of the last frame
	logic clear;      // result queue flush

	// frame receiver side
	modport src (
		output restart,
		output push,
		output job,
		output clear
	);

	// job queue side
	modport queue (input restart, input push, input job);

	// result path only cares about the restart
	modport flush (input restart);

endinterface

`default_nettype wire

//--- source/sync_fifo.sv
// show-ahead fifo; DEPTH must be a power of two; caller must not read empty or write full
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             i_flush,     // empties on the next edge
	input  wire logic             i_wr_en,
	input  wire logic [WIDTH-1:0] i_wr_data,
	input  wire logic             i_rd_en,
	output logic      [WIDTH-1:0] o_rd_data,   // oldest entry, valid when not empty
	output logic                  o_empty,
	output logic                  o_full
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;    // one extra bit to tell full from empty

	// storage, no reset needed
	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[wr_ptr] <= i_wr_data;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (rst || i_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_wr_en) wr_ptr <= wr_ptr + 1'b1;    // wraps at DEPTH
			if (i_rd_en) rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(i_wr_en) - (AW+1)'(i_rd_en);
		end
	end

	assign o_rd_data = mem[rd_ptr];    // show-ahead
	assign o_empty   = (count == '0);
	assign o_full    = (count == (AW+1)'(DEPTH));

	// users gate their strobes with the flags
	a_no_rd_empty: assert property (@(posedge clk) disable iff (rst) i_rd_en |-> !o_empty);
	a_no_wr_full:  assert property (@(posedge clk) disable iff (rst) i_wr_en |-> !o_full);

endmodule

`default_nettype wire

//--- source/cmd_frame_rx.sv
// no resync within a frame; byte count only realigns at reset, and unknown control codes are dropped
`timescale 1ns/1ps
`default_nettype none

module cmd_frame_rx (
	input  wire logic                              clk,
	input  wire logic                              rst,
	input  wire logic [miner_link_pkg::BYTE_W-1:0] i_rx_data,
	input  wire logic                              i_rx_data_vld,   // one byte per cycle
	job_if.src                                     o_job
);

	import miner_link_pkg::*;

	localparam int CNT_W = $clog2(FRAME_BYTES);

	logic [CNT_W-1:0] byte_cnt;     // position within the frame
	ctrl_op_e         ctrl_q;       // control byte of the current frame
	job_t             job_q;        // job bytes, shifted in msb first
	logic             restart_q;
	logic             push_q;
	logic             last_byte;

	assign last_byte = i_rx_data_vld && (byte_cnt == CNT_W'(FRAME_BYTES - 1));

	// ************************************************************************
	// frame position
	// ************************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			byte_cnt <= '0;
		end else if (last_byte) begin
			byte_cnt <= '0;                  // wrap, next byte is control
		end else if (i_rx_data_vld) begin
			byte_cnt <= byte_cnt + 1'b1;
		end
	end

	// control byte, byte 0 only
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl_q <= OP_NONE;
		end else if (i_rx_data_vld && (byte_cnt == '0)) begin
			ctrl_q <= ctrl_op_e'(i_rx_data);    // unknown codes kept as is
		end
	end

	// job shift register, bytes 1 to 112
	// payload, holds until the next frame overwrites it
	always_ff @(posedge clk) begin
		if (i_rx_data_vld && (byte_cnt != '0)) begin
			job_q <= {job_q[JOB_W-BYTE_W-1:0], i_rx_data};
		end
	end

	// ************************************************************************
	// end of frame strobes
	// ************************************************************************
	// one cycle after the last byte, job_q then holds the complete job
	always_ff @(posedge clk) begin
		if (rst) begin
			restart_q <= 1'b0;
			push_q    <= 1'b0;
		end else begin
			restart_q <= last_byte && (ctrl_q == OP_RESTART);
			push_q    <= last_byte && (ctrl_q == OP_MERKLE);
		end
	end

	assign o_job.restart = restart_q;
	assign o_job.push    = push_q;
	assign o_job.job     = job_q;
	assign o_job.clear   = restart_q;    // result flush follows restart

	// a frame ends in at most one strobe
	a_one_strobe: assert property (
		@(posedge clk) disable iff (rst) !(o_job.restart && o_job.push)
	);

endmodule

`default_nettype wire

//--- source/job_queue.sv
// jobs beyond JOB_DEPTH overflow the queue; the core must not report full during a restart
`timescale 1ns/1ps
`default_nettype none

module job_queue (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          i_mining_nounce_full,   // core wants the next job
	job_if.queue               i_job,
	output logic               o_mining_en,            // job outputs valid this cycle
	output miner_link_pkg::job_t o_mining_job
);

	import miner_link_pkg::*;

	logic fifo_empty;
	logic fifo_full;
	logic pop;
	job_t fifo_job;

	// pop only when nothing is being forced in by a restart
	assign pop = !fifo_empty && i_mining_nounce_full && !i_job.restart;

	// ************************************************************************
	// merkle job storage
	// ************************************************************************
	sync_fifo #(
		.WIDTH (JOB_W),
		.DEPTH (JOB_DEPTH)
	) job_fifo_inst (
		.clk       (clk),
		.rst       (rst),
		.i_flush   (i_job.restart),    // restart drops all queued merkle work
		.i_wr_en   (i_job.push),
		.i_wr_data (i_job.job),
		.i_rd_en   (pop),
		.o_rd_data (fifo_job),
		.o_empty   (fifo_empty),
		.o_full    (fifo_full)
	);

	// ************************************************************************
	// output select
	// ************************************************************************
	always_comb begin
		if (i_job.restart) begin
			o_mining_job = i_job.job;      // straight from the frame
		end else if (pop) begin
			o_mining_job = fifo_job;       // show-ahead head
		end else begin
			o_mining_job = '0;
		end
	end

	assign o_mining_en = i_job.restart || pop;

	// queue overflow means jobs were sent faster than the core asked
	a_no_overflow: assert property (
		@(posedge clk) disable iff (rst) i_job.push |-> !fifo_full
	);

endmodule

`default_nettype wire

//--- source/result_tx.sv
// one byte outstanding at a time; records that find the queue full are lost, reports are blanked after restart
`timescale 1ns/1ps
`default_nettype none

module result_tx (
	input  wire logic                              clk,
	input  wire logic                              rst,
	input  wire logic [miner_link_pkg::WORD_W-1:0] i_mining_nounce,
	input  wire logic [miner_link_pkg::WORD_W-1:0] i_mining_extranounce2,
	input  wire logic                              i_mining_nounce_vld,    // nonce found
	input  wire logic                              i_mining_nounce_full,   // nonce space done
	input  wire logic                              i_rx_busy,              // frame coming in
	input  wire logic                              i_tx_done,              // byte finished
	job_if.flush                                   i_flush,
	output logic      [miner_link_pkg::BYTE_W-1:0] o_tx_data,
	output logic                                   o_tx_data_vld           // one-cycle pulse
);

	import miner_link_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_SEND
	} tx_state_e;

	localparam int IDX_W = $clog2(RECORD_BYTES);

	logic [BLANK_CYCLES-1:0] restart_dly;   // restart history
	logic                    blanking;
	logic                    rec_wr;
	logic [RECORD_W-1:0]     rec_wr_data;
	logic [RECORD_W-1:0]     rec_head;
	logic                    rec_empty;
	logic                    rec_full;
	logic                    rec_rd;
	logic [RECORD_W-1:0]     rec_q;         // record being sent
	tx_state_e               state_q;
	logic [IDX_W-1:0]        idx_q;         // byte index, 0 is the flag byte
	logic                    tx_vld_q;

	// ************************************************************************
	// blanking and capture
	// ************************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			restart_dly <= '0;
		end else begin
			restart_dly <= {restart_dly[BLANK_CYCLES-2:0], i_flush.restart};
		end
	end

	// restart cycle plus BLANK_CYCLES after it
	assign blanking = i_flush.restart || (|restart_dly);

	// full queue just drops the report
	assign rec_wr = !blanking && !rec_full && (i_mining_nounce_vld || i_mining_nounce_full);
	assign rec_wr_data = {6'b0, i_mining_nounce_full, i_mining_nounce_vld,
		i_mining_nounce, i_mining_extranounce2};

	sync_fifo #(
		.WIDTH (RECORD_W),
		.DEPTH (RESULT_DEPTH)
	) rec_fifo_inst (
		.clk       (clk),
		.rst       (rst),
		.i_flush   (i_flush.restart),
		.i_wr_en   (rec_wr),
		.i_wr_data (rec_wr_data),
		.i_rd_en   (rec_rd),
		.o_rd_data (rec_head),
		.o_empty   (rec_empty),
		.o_full    (rec_full)
	);

	// ************************************************************************
	// serializer
	// ************************************************************************
	// never pops while blanking, so no pop meets a flush
	assign rec_rd = (state_q == ST_IDLE) && !i_rx_busy && !rec_empty && !blanking;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q  <= ST_IDLE;
			idx_q    <= '0;
			tx_vld_q <= 1'b0;
		end else begin
			tx_vld_q <= 1'b0;    // pulse by default
			case (state_q)
				ST_IDLE: if (rec_rd) begin
					state_q  <= ST_SEND;
					idx_q    <= '0;
					tx_vld_q <= 1'b1;    // flag byte next cycle
				end
				ST_SEND: if (i_tx_done) begin
					if (idx_q == IDX_W'(RECORD_BYTES - 1)) begin
						state_q <= ST_IDLE;          // record done
					end else begin
						idx_q    <= idx_q + 1'b1;
						tx_vld_q <= 1'b1;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// record payload, loaded on pop
	always_ff @(posedge clk) begin
		if (rec_rd) rec_q <= rec_head;
	end

	assign o_tx_data     = rec_q[(RECORD_BYTES - 1 - int'(idx_q)) * BYTE_W +: BYTE_W];    // msb first
	assign o_tx_data_vld = tx_vld_q;

	// transmitter only answers bytes we sent
	a_no_done_idle: assert property (
		@(posedge clk) disable iff (rst) i_tx_done |-> state_q == ST_SEND
	);

endmodule

`default_nettype wire

//--- source/miner_link_top.sv
// byte-level link only; an external UART supplies rx bytes and completes tx bytes with i_tx_done
`timescale 1ns/1ps
`default_nettype none

module miner_link_top (
	input  wire logic                                clk,
	input  wire logic                                rst,
	input  wire logic [miner_link_pkg::BYTE_W-1:0]   i_rx_data,
	input  wire logic                                i_rx_data_vld,
	input  wire logic                                i_rx_busy,
	input  wire logic                                i_tx_done,
	input  wire logic [miner_link_pkg::WORD_W-1:0]   i_mining_extranounce2,
	input  wire logic [miner_link_pkg::WORD_W-1:0]   i_mining_nounce,
	input  wire logic                                i_mining_nounce_vld,
	input  wire logic                                i_mining_nounce_full,
	output logic                                     o_mining_en,
	output logic      [miner_link_pkg::BLOCK_W-1:0]  o_mining_data,
	output logic      [miner_link_pkg::TARGET_W-1:0] o_mining_target,
	output logic      [miner_link_pkg::WORD_W-1:0]   o_mining_extranounce2,
	output logic      [miner_link_pkg::BYTE_W-1:0]   o_tx_data,
	output logic                                     o_tx_data_vld
);

	import miner_link_pkg::*;

	job_t mining_job;    // selected job toward the core

	job_if job_bus ();

	// ************************************************************************
	// command path
	// ************************************************************************
	cmd_frame_rx cmd_frame_rx_inst (
		.clk           (clk),
		.rst           (rst),
		.i_rx_data     (i_rx_data),
		.i_rx_data_vld (i_rx_data_vld),
		.o_job         (job_bus.src)
	);

	job_queue job_queue_inst (
		.clk                  (clk),
		.rst                  (rst),
		.i_mining_nounce_full (i_mining_nounce_full),
		.i_job                (job_bus.queue),
		.o_mining_en          (o_mining_en),
		.o_mining_job         (mining_job)
	);

	// split into the core's ports
	assign o_mining_data         = mining_job.block;
	assign o_mining_extranounce2 = mining_job.extranonce2;
	assign o_mining_target       = mining_job.target;

	// result path
	result_tx result_tx_inst (
		.clk                   (clk),
		.rst                   (rst),
		.i_mining_nounce       (i_mining_nounce),
		.i_mining_extranounce2 (i_mining_extranounce2),
		.i_mining_nounce_vld   (i_mining_nounce_vld),
		.i_mining_nounce_full  (i_mining_nounce_full),
		.i_rx_busy             (i_rx_busy),
		.i_tx_done             (i_tx_done),
		.i_flush               (job_bus.flush),
		.o_tx_data             (o_tx_data),
		.o_tx_data_vld         (o_tx_data_vld)
	);

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
// free-running 8 ns clock; reset is high for the first 2 rising edges, then low for good
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;    // 8 ns period
	end

	initial begin
		o_rst = 1'b1;
		repeat (2) @(posedge o_clk);
		o_rst <= 1'b0;    // released on the second edge
	end

endmodule

`default_nettype wire

//--- bench/miner_link_tb.sv
// directed tests only; the transmitter model is always on and job data come from a fixed seed
`timescale 1ns/1ps
`default_nettype none

module miner_link_tb;

	import miner_link_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000;    // ~10 frames plus ~8 records at 9 cycles per byte
	localparam int QUIET_CYCLES   = 24;       // longer than any gap inside a record

	logic                clk;
	logic                rst;
	logic [BYTE_W-1:0]   i_rx_data;
	logic                i_rx_data_vld;
	logic                i_rx_busy;
	logic                i_tx_done;
	logic [WORD_W-1:0]   i_mining_extranounce2;
	logic [WORD_W-1:0]   i_mining_nounce;
	logic                i_mining_nounce_vld;
	logic                i_mining_nounce_full;
	logic                o_mining_en;
	logic [BLOCK_W-1:0]  o_mining_data;
	logic [TARGET_W-1:0] o_mining_target;
	logic [WORD_W-1:0]   o_mining_extranounce2;
	logic [BYTE_W-1:0]   o_tx_data;
	logic                o_tx_data_vld;

	int          errors = 0;
	int          checks = 0;
	int          cycle_cnt = 0;
	logic [31:0] delay_state = 32'd3;    // transmitter delays
	logic [31:0] data_state = 32'd3;     // job contents
	job_t        mined_jobs[$];          // every cycle with o_mining_en high
	logic [7:0]  tx_bytes[$];            // bytes taken by the transmitter model

	tb_clock_gen tb_clock_gen_inst (.o_clk(clk), .o_rst(rst));

	miner_link_top miner_link_top_inst (
		.clk                   (clk),
		.rst                   (rst),
		.i_rx_data             (i_rx_data),
		.i_rx_data_vld         (i_rx_data_vld),
		.i_rx_busy             (i_rx_busy),
		.i_tx_done             (i_tx_done),
		.i_mining_extranounce2 (i_mining_extranounce2),
		.i_mining_nounce       (i_mining_nounce),
		.i_mining_nounce_vld   (i_mining_nounce_vld),
		.i_mining_nounce_full  (i_mining_nounce_full),
		.o_mining_en           (o_mining_en),
		.o_mining_data         (o_mining_data),
		.o_mining_target       (o_mining_target),
		.o_mining_extranounce2 (o_mining_extranounce2),
		.o_tx_data             (o_tx_data),
		.o_tx_data_vld         (o_tx_data_vld)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ************************************************************************
	// monitors, transmitter model, timeout
	// ************************************************************************
	always @(negedge clk) begin
		if (!rst && o_mining_en) begin
			mined_jobs.push_back({o_mining_data, o_mining_extranounce2, o_mining_target});
		end else if (!rst) begin
			assert (o_mining_data == '0 && o_mining_extranounce2 == '0 && o_mining_target == '0)
			else begin
				errors++;
				$display("ERROR: job outputs are not zero while o_mining_en is low");
			end
		end
	end

	// one byte in flight, done after 1 to 8 cycles
	always begin : tx_model
		int delay;
		@(negedge clk);
		if (!rst && o_tx_data_vld) begin
			tx_bytes.push_back(o_tx_data);
			delay_state = xorshift32(delay_state);
			delay = int'(delay_state[2:0]) + 1;
			repeat (delay) @(posedge clk);
			i_tx_done <= 1'b1;
			@(posedge clk);
			i_tx_done <= 1'b0;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	// ************************************************************************
	// helpers
	// ************************************************************************
	task automatic check_value(input string name, input logic [JOB_W-1:0] expected,
			input logic [JOB_W-1:0] actual);
		checks++;
		assert (actual == expected) else begin
			errors++;
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic check_job(input string name, input job_t expected, input job_t actual);
		check_value({name, " block"}, JOB_W'(expected.block), JOB_W'(actual.block));
		check_value({name, " extranonce2"}, JOB_W'(expected.extranonce2),
			JOB_W'(actual.extranonce2));
		check_value({name, " target"}, JOB_W'(expected.target), JOB_W'(actual.target));
	endtask

	// flag, nonce, extranonce2, msb byte first on the wire
	task automatic check_record(input string name, input int base, input logic [7:0] flag,
			input logic [31:0] nonce, input logic [31:0] extra);
		logic [RECORD_W-1:0] rec;
		int                  i;
		rec = {flag, nonce, extra};
		for (i = 0; i < RECORD_BYTES; i++) begin
			check_value($sformatf("%s byte %0d", name, i),
				JOB_W'(rec[RECORD_W - 1 - 8 * i -: 8]), JOB_W'(tx_bytes[base + i]));
		end
	endtask

	task automatic make_job(output job_t job);
		logic [JOB_W-1:0] bits;
		int               w;
		for (w = 0; w < JOB_W / 32; w++) begin
			data_state = xorshift32(data_state);
			bits[w * 32 +: 32] = data_state;
		end
		job = bits;
	endtask

	// bytes back to back; returns on the edge that takes the last byte
	task automatic send_frame(input logic [7:0] ctrl, input job_t job);
		logic [JOB_W-1:0] payload;
		int               i;
		payload = job;
		@(posedge clk);
		i_rx_busy     <= 1'b1;
		i_rx_data_vld <= 1'b1;
		i_rx_data     <= ctrl;
		for (i = 0; i < FRAME_BYTES - 1; i++) begin
			@(posedge clk);
			i_rx_data <= payload[JOB_W - 1 - 8 * i -: 8];    // big-endian
		end
		@(posedge clk);
		i_rx_data_vld <= 1'b0;
		i_rx_busy     <= 1'b0;
	endtask

	// one-cycle report from the core
	task automatic give_report(input logic vld, input logic full, input logic [31:0] nonce,
			input logic [31:0] extra);
		@(posedge clk);
		i_mining_nounce       <= nonce;
		i_mining_extranounce2 <= extra;
		i_mining_nounce_vld   <= vld;
		i_mining_nounce_full  <= full;
		@(posedge clk);
		i_mining_nounce_vld  <= 1'b0;
		i_mining_nounce_full <= 1'b0;
	endtask

	task automatic wait_tx_quiet();
		int idle;
		idle = 0;
		while (idle < QUIET_CYCLES) begin
			@(negedge clk);
			if (o_tx_data_vld || i_tx_done) idle = 0;
			else idle++;
		end
		tx_bytes.delete();
	endtask

	task automatic wait_tx_bytes(input int n);
		while (tx_bytes.size() < n) @(negedge clk);
	endtask

	// ************************************************************************
	// directed tests
	// ************************************************************************
	task automatic merkle_queueing();
		job_t job;
		make_job(job);
		@(posedge clk);
		mined_jobs.delete();
		send_frame(OP_MERKLE, job);
		repeat (10) @(posedge clk);
		check_value("merkle_queueing early enables", '0, JOB_W'(mined_jobs.size()));
		give_report(1'b0, 1'b1, 32'h0, 32'h0);
		repeat (2) @(posedge clk);
		check_value("merkle_queueing enables", JOB_W'(1), JOB_W'(mined_jobs.size()));
		check_job("merkle_queueing", job, mined_jobs[0]);
	endtask

	task automatic restart_flush();
		job_t m0;
		job_t m1;
		job_t rs;
		make_job(m0);
		make_job(m1);
		make_job(rs);
		send_frame(OP_MERKLE, m0);
		send_frame(OP_MERKLE, m1);
		send_frame(OP_RESTART, rs);
		@(negedge clk);    // cycle after the last byte
		check_value("restart_flush en", JOB_W'(1), JOB_W'(o_mining_en));
		check_job("restart_flush", rs, {o_mining_data, o_mining_extranounce2, o_mining_target});
		repeat (8) @(posedge clk);
		mined_jobs.delete();
		give_report(1'b0, 1'b1, 32'h0, 32'h0);    // merkle jobs must be gone
		repeat (2) @(posedge clk);
		check_value("restart_flush enables", '0, JOB_W'(mined_jobs.size()));
	endtask

	task automatic ignored_control();
		job_t job;
		make_job(job);
		@(posedge clk);
		mined_jobs.delete();
		send_frame(8'h07, job);
		repeat (4) @(posedge clk);
		give_report(1'b0, 1'b1, 32'h0, 32'h0);
		repeat (2) @(posedge clk);
		check_value("ignored_control enables", '0, JOB_W'(mined_jobs.size()));
	endtask

	task automatic queue_order();
		job_t a;
		job_t b;
		make_job(a);
		make_job(b);
		@(posedge clk);
		mined_jobs.delete();
		send_frame(OP_MERKLE, a);
		send_frame(OP_MERKLE, b);
		give_report(1'b0, 1'b1, 32'h0, 32'h0);
		repeat (3) @(posedge clk);
		give_report(1'b0, 1'b1, 32'h0, 32'h0);
		repeat (2) @(posedge clk);
		check_value("queue_order enables", JOB_W'(2), JOB_W'(mined_jobs.size()));
		check_job("queue_order first", a, mined_jobs[0]);
		check_job("queue_order second", b, mined_jobs[1]);
	endtask

	task automatic nonce_records();
		wait_tx_quiet();    // drain records left by the full reports above
		give_report(1'b1, 1'b0, 32'hdeadbeef, 32'h01234567);
		give_report(1'b0, 1'b1, 32'hcafef00d, 32'h89abcdef);
		wait_tx_bytes(2 * RECORD_BYTES);
		repeat (QUIET_CYCLES) @(negedge clk);    // nothing more may follow
		check_value("nonce_records byte count", JOB_W'(2 * RECORD_BYTES),
			JOB_W'(tx_bytes.size()));
		check_record("nonce_records vld", 0, 8'h01, 32'hdeadbeef, 32'h01234567);
		check_record("nonce_records full", RECORD_BYTES, 8'h02, 32'hcafef00d, 32'h89abcdef);
	endtask

	task automatic holdoff_blanking();
		job_t rs;
		wait_tx_quiet();
		@(posedge clk);
		i_rx_busy <= 1'b1;
		give_report(1'b1, 1'b0, 32'h11223344, 32'h55667788);
		repeat (30) @(posedge clk);
		check_value("holdoff bytes while busy", '0, JOB_W'(tx_bytes.size()));
		i_rx_busy <= 1'b0;
		wait_tx_bytes(RECORD_BYTES);
		check_record("holdoff", 0, 8'h01, 32'h11223344, 32'h55667788);
		wait_tx_quiet();
		make_job(rs);
		send_frame(OP_RESTART, rs);    // restart pulse in the next cycle
		repeat (2) @(posedge clk);
		give_report(1'b1, 1'b0, 32'hbadbad00, 32'hbadbad11);    // 3 cycles after, blanked
		repeat (5) @(posedge clk);
		give_report(1'b1, 1'b0, 32'h600d600d, 32'h600d6011);    // 10 cycles after
		wait_tx_bytes(RECORD_BYTES);
		repeat (QUIET_CYCLES) @(negedge clk);
		check_value("blanking byte count", JOB_W'(RECORD_BYTES), JOB_W'(tx_bytes.size()));
		check_record("blanking", 0, 8'h01, 32'h600d600d, 32'h600d6011);
	endtask

	// ************************************************************************
	// main sequence
	// ************************************************************************
	initial begin
		i_rx_data             = '0;
		i_rx_data_vld         = 1'b0;
		i_rx_busy             = 1'b0;
		i_tx_done             = 1'b0;
		i_mining_extranounce2 = '0;
		i_mining_nounce       = '0;
		i_mining_nounce_vld   = 1'b0;
		i_mining_nounce_full  = 1'b0;
		@(posedge clk);
		while (rst) @(posedge clk);
		merkle_queueing();
		restart_flush();
		ignored_control();
		queue_order();
		nonce_records();
		holdoff_blanking();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- miner_link.f
source/miner_link_pkg.sv
source/job_if.sv
source/sync_fifo.sv
source/cmd_frame_rx.sv
source/job_queue.sv
source/result_tx.sv
source/miner_link_top.sv
bench/tb_clock_gen.sv
bench/miner_link_tb.sv

//--- Makefile
# Verilator build and run for the miner_link testbench
VERILATOR ?= verilator
TOP       ?= miner_link_tb
FILELIST  ?= miner_link.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
